// File: design/sdram_pkg.sv
package sdram_pkg;

	// address split of the sdram array
	localparam int COL_BITS = 9;
	localparam int ROW_BITS = 13;
	localparam int BANK_BITS = 2;

	// fixed by MODE_REG below
	localparam int CAS_LATENCY = 2;
	localparam int BURST_LEN = 2;

	localparam logic [ROW_BITS-1:0] MODE_REG = 13'h021; // bl 2, sequential, cl 2
	localparam logic [ROW_BITS-1:0] EXT_MODE_REG = 13'h000;

	// a10 selects all banks on precharge, auto-precharge on read/write
	localparam int AUTO_PRECHARGE_BIT = 10;

	// ras_n, cas_n, we_n with cs_n tied low
	typedef enum logic [2:0] {
		CMD_MRS       = 3'b000,
		CMD_REFRESH   = 3'b001,
		CMD_PRECHARGE = 3'b010,
		CMD_ACTIVE    = 3'b011,
		CMD_WRITE     = 3'b100,
		CMD_READ      = 3'b101,
		CMD_NOP       = 3'b111
	} sdram_cmd_e;

	typedef struct packed {
		sdram_cmd_e cmd;
		logic [ROW_BITS-1:0] addr;
		logic [BANK_BITS-1:0] bank;
	} sdram_pins_t;

	localparam sdram_pins_t PINS_NOP = '{
		cmd: CMD_NOP,
		addr: '0,
		bank: '0
	};

endpackage

// File: design/sdram_init.sv
`timescale 1ns/1ns
module sdram_init #(
	parameter int POWERUP_CYCLES = 200,
	parameter int CMD_GAP = 4,
	parameter int SETTLE_CYCLES = 16
) (
	input logic clk_n,
	input logic rst,
	output logic cke,
	output sdram_pkg::sdram_pins_t init_pins,
	output logic init_done
);
	localparam int WAIT_W = $clog2(POWERUP_CYCLES + SETTLE_CYCLES + 1);
	localparam int GAP_W = $clog2(CMD_GAP + 2);
	localparam logic [2:0] LAST_STAGE = 3'd6;
	localparam logic [12:0] PALL_ADDR = 13'd1 << sdram_pkg::AUTO_PRECHARGE_BIT;

	typedef enum logic [1:0] {
		POWERUP,
		SEQUENCE,
		SETTLE,
		DONE
	} init_state_e;

	init_state_e state;
	logic [WAIT_W-1:0] wait_cnt;
	logic [GAP_W-1:0] gap_cnt;
	logic [2:0] stage;
	sdram_pkg::sdram_pins_t rom_pins;

	// seven-entry init command table
	always_comb
	begin
		rom_pins = sdram_pkg::PINS_NOP;
		case (stage)
			3'd0, 3'd3:
			begin
				rom_pins.cmd = sdram_pkg::CMD_PRECHARGE; // all banks
				rom_pins.addr = PALL_ADDR;
			end
			3'd1:
			begin
				rom_pins.cmd = sdram_pkg::CMD_MRS;
				rom_pins.addr = sdram_pkg::EXT_MODE_REG;
				rom_pins.bank = 2'd1; // extended register
			end
			3'd2, 3'd6:
			begin
				rom_pins.cmd = sdram_pkg::CMD_MRS;
				rom_pins.addr = sdram_pkg::MODE_REG;
			end
			3'd4, 3'd5:
				rom_pins.cmd = sdram_pkg::CMD_REFRESH;
			default:
				rom_pins = sdram_pkg::PINS_NOP;
		endcase
	end

	always_ff @(posedge clk_n)
	begin
		if (!rst)
		begin
			state <= POWERUP;
			cke <= 1'b0;
			init_done <= 1'b0;
			init_pins <= sdram_pkg::PINS_NOP;
			wait_cnt <= '0;
			gap_cnt <= '0;
			stage <= '0;
		end
		else
		begin
			init_pins <= sdram_pkg::PINS_NOP; // nop between table entries
			case (state)
				POWERUP:
					if (wait_cnt == WAIT_W'(POWERUP_CYCLES - 1))
					begin
						cke <= 1'b1;
						state <= SEQUENCE;
					end
					else
						wait_cnt <= wait_cnt + 1'b1;
				SEQUENCE:
					if (gap_cnt == GAP_W'(CMD_GAP))
					begin
						init_pins <= rom_pins;
						gap_cnt <= '0;
						stage <= stage + 1'b1;
						if (stage == LAST_STAGE)
						begin
							wait_cnt <= WAIT_W'(1); // counts from the last command
							state <= SETTLE;
						end
					end
					else
						gap_cnt <= gap_cnt + 1'b1;
				SETTLE:
					if (wait_cnt == WAIT_W'(SETTLE_CYCLES))
					begin
						init_done <= 1'b1;
						state <= DONE;
					end
					else
						wait_cnt <= wait_cnt + 1'b1;
				default:
					state <= DONE;
			endcase
		end
	end

endmodule

// File: design/sdram_refresh.sv
`timescale 1ns/1ns
module sdram_refresh #(
	parameter int REFRESH_INTERVAL = 300
) (
	input logic clk_n,
	input logic rst,
	input logic init_done,
	input logic ref_ack,
	output logic ref_req
);
	localparam int CNT_W = $clog2(REFRESH_INTERVAL + 1);

	logic [CNT_W-1:0] interval_cnt;

	// the request stays up until the arbiter issues refresh,
	// so a refresh held back by a long access is only late
	always_ff @(posedge clk_n)
	begin
		if (!rst)
		begin
			interval_cnt <= '0;
			ref_req <= 1'b0;
		end
		else if (ref_ack)
		begin
			interval_cnt <= '0; // restart interval
			ref_req <= 1'b0;
		end
		else if (init_done && !ref_req)
		begin
			if (interval_cnt == CNT_W'(REFRESH_INTERVAL - 1))
				ref_req <= 1'b1;
			else
				interval_cnt <= interval_cnt + 1'b1;
		end
	end

endmodule

// File: design/sdram_access.sv
`timescale 1ns/1ns
module sdram_access #(
	parameter int T_RCD = 2,
	parameter int T_RECOVERY = 3
) (
	input logic clk_n,
	input logic rst,
	input logic init_done,
	input logic [31:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [31:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic acc_req,
	input logic acc_grant,
	output sdram_pkg::sdram_pins_t acc_pins,
	output logic acc_done,
	output logic [15:0] dq_out,
	output logic dq_oe,
	input logic [15:0] dq_in
);
	localparam int ROW_LSB = sdram_pkg::COL_BITS + 1;
	localparam int BANK_LSB = ROW_LSB + sdram_pkg::ROW_BITS;
	localparam int RD_LAST = sdram_pkg::CAS_LATENCY + sdram_pkg::BURST_LEN - 1;
	localparam int CNT_W = $clog2(T_RCD + T_RECOVERY + RD_LAST + 1);

	typedef enum logic [2:0] {
		IDLE,
		REQ,
		ACT,
		RCD,
		CMD,
		DATA,
		RECOVER,
		RESP
	} acc_state_e;

	acc_state_e state;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] data_last;
	logic is_write;
	logic [sdram_pkg::BANK_BITS-1:0] bank_q;
	logic [sdram_pkg::ROW_BITS-1:0] row_q;
	logic [sdram_pkg::COL_BITS-1:0] col_q;
	logic [31:0] wdata_q;
	logic [31:0] rdata_q;
	logic [31:0] addr_sel;
	logic idle_rdy;
	logic rd_take;
	logic wr_take;

	assign idle_rdy = (state == IDLE) && init_done;
	assign rd_take = idle_rdy && arvalid; // reads first
	assign wr_take = idle_rdy && !arvalid && awvalid && wvalid; // aw and w taken together
	assign arready = idle_rdy;
	assign awready = wr_take;
	assign wready = wr_take;
	assign addr_sel = rd_take ? araddr : awaddr;

	assign acc_req = (state == REQ);
	assign bvalid = (state == RESP) && is_write;
	assign rvalid = (state == RESP) && !is_write;
	assign bresp = 2'b00; // always okay
	assign rresp = 2'b00;
	assign rdata = rdata_q;

	// write ends with the last beat, read waits out cas latency too
	assign data_last = is_write ? CNT_W'(sdram_pkg::BURST_LEN - 1) : CNT_W'(RD_LAST);

	always_comb
	begin
		acc_pins = sdram_pkg::PINS_NOP;
		if (state == ACT)
		begin
			acc_pins.cmd = sdram_pkg::CMD_ACTIVE;
			acc_pins.addr = row_q;
			acc_pins.bank = bank_q;
		end
		else if (state == CMD)
		begin
			acc_pins.cmd = is_write ? sdram_pkg::CMD_WRITE : sdram_pkg::CMD_READ;
			acc_pins.addr = 13'(col_q);
			acc_pins.addr[sdram_pkg::AUTO_PRECHARGE_BIT] = 1'b1; // close row after burst
			acc_pins.bank = bank_q;
		end
	end

	always_ff @(posedge clk_n)
	begin
		if (!rst)
		begin
			state <= IDLE;
			cnt <= '0;
			acc_done <= 1'b0;
			dq_oe <= 1'b0;
		end
		else
		begin
			acc_done <= 1'b0;
			// pins lag the state by one cycle in the arbiter, dq follows the pins
			dq_oe <= is_write && ((state == CMD) ||
				((state == DATA) && (cnt < CNT_W'(sdram_pkg::BURST_LEN - 1))));
			case (state)
				IDLE:
					if (rd_take || wr_take)
						state <= REQ;
				REQ:
					if (acc_grant)
						state <= ACT;
				ACT:
				begin
					cnt <= '0;
					state <= RCD;
				end
				RCD:
					if (cnt == CNT_W'(T_RCD - 1))
						state <= CMD;
					else
						cnt <= cnt + 1'b1;
				CMD:
				begin
					cnt <= '0;
					state <= DATA;
				end
				DATA:
					if (cnt == data_last)
					begin
						cnt <= '0;
						state <= RECOVER;
					end
					else
						cnt <= cnt + 1'b1;
				RECOVER:
					if (cnt == CNT_W'(T_RECOVERY - 1))
					begin
						acc_done <= 1'b1; // same cycle as bvalid/rvalid
						state <= RESP;
					end
					else
						cnt <= cnt + 1'b1;
				RESP:
					if (is_write ? bready : rready)
						state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_n)
	begin
		if (rd_take || wr_take)
		begin
			is_write <= wr_take;
			bank_q <= addr_sel[BANK_LSB+sdram_pkg::BANK_BITS-1:BANK_LSB];
			row_q <= addr_sel[BANK_LSB-1:ROW_LSB];
			col_q <= {addr_sel[sdram_pkg::COL_BITS:2], 1'b0}; // even column, two beats
			wdata_q <= wdata;
		end
		if (state == CMD)
			dq_out <= wdata_q[15:0]; // low half first
		else if (state == DATA)
			dq_out <= wdata_q[31:16];
		if ((state == DATA) && !is_write)
		begin
			if (cnt == CNT_W'(sdram_pkg::CAS_LATENCY))
				rdata_q[15:0] <= dq_in;
			if (cnt == CNT_W'(sdram_pkg::CAS_LATENCY + 1))
				rdata_q[31:16] <= dq_in;
		end
	end

endmodule

// File: design/sdram_cmd_arbiter.sv
`timescale 1ns/1ns
module sdram_cmd_arbiter #(
	parameter int T_RFC = 6
) (
	input logic clk_n,
	input logic rst,
	input logic init_done,
	input sdram_pkg::sdram_pins_t init_pins,
	input logic ref_req,
	input logic acc_req,
	input sdram_pkg::sdram_pins_t acc_pins,
	input logic acc_done,
	output logic ref_ack,
	output logic acc_grant,
	output sdram_pkg::sdram_pins_t pins
);
	localparam int RFC_W = $clog2(T_RFC + 1);
	localparam sdram_pkg::sdram_pins_t PINS_REFRESH = '{
		cmd: sdram_pkg::CMD_REFRESH,
		addr: '0,
		bank: '0
	};

	typedef enum logic [1:0] {
		IDLE,
		REFRESH,
		ACCESS
	} arb_state_e;

	arb_state_e state;
	logic [RFC_W-1:0] rfc_cnt;
	sdram_pkg::sdram_pins_t pins_q;

	// init sequence goes straight to the pins
	assign pins = init_done ? pins_q : init_pins;

	always_ff @(posedge clk_n)
	begin
		if (!rst)
		begin
			state <= IDLE;
			rfc_cnt <= '0;
			ref_ack <= 1'b0;
			acc_grant <= 1'b0;
			pins_q <= sdram_pkg::PINS_NOP;
		end
		else
		begin
			ref_ack <= 1'b0;
			pins_q <= sdram_pkg::PINS_NOP;
			case (state)
				IDLE:
					if (init_done && ref_req)
					begin
						pins_q <= PINS_REFRESH;
						ref_ack <= 1'b1; // pulse with the command
						rfc_cnt <= '0;
						state <= REFRESH;
					end
					else if (init_done && acc_req)
					begin
						acc_grant <= 1'b1;
						state <= ACCESS;
					end
				REFRESH:
					if (rfc_cnt == RFC_W'(T_RFC - 1))
						state <= IDLE;
					else
						rfc_cnt <= rfc_cnt + 1'b1;
				ACCESS:
				begin
					pins_q <= acc_pins;
					if (acc_done)
					begin
						acc_grant <= 1'b0;
						state <= IDLE;
					end
				end
				default:
					state <= IDLE;
			endcase
		end
	end

endmodule

// File: design/sdram_ctrl_top.sv
`timescale 1ns/1ns
module sdram_ctrl_top #(
	parameter int POWERUP_CYCLES = 200,
	parameter int CMD_GAP = 4,
	parameter int SETTLE_CYCLES = 16,
	parameter int REFRESH_INTERVAL = 300,
	parameter int T_RCD = 2,
	parameter int T_RFC = 6,
	parameter int T_RECOVERY = 3
) (
	input logic clk_n,
	input logic rst,
	input logic [31:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [31:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic cke,
	output sdram_pkg::sdram_cmd_e cmd,
	output logic [12:0] addr,
	output logic [1:0] bank,
	output logic [15:0] dq_out,
	output logic dq_oe,
	input logic [15:0] dq_in
);
	sdram_pkg::sdram_pins_t init_pins;
	sdram_pkg::sdram_pins_t acc_pins;
	sdram_pkg::sdram_pins_t pins;
	logic init_done;
	logic ref_req;
	logic ref_ack;
	logic acc_req;
	logic acc_grant;
	logic acc_done;

	assign cmd = pins.cmd;
	assign addr = pins.addr;
	assign bank = pins.bank;

	sdram_init #(
		.POWERUP_CYCLES(POWERUP_CYCLES),
		.CMD_GAP(CMD_GAP),
		.SETTLE_CYCLES(SETTLE_CYCLES)
	) sdram_init_i (
		.clk_n(clk_n),
		.rst(rst),
		.cke(cke),
		.init_pins(init_pins),
		.init_done(init_done)
	);

	sdram_refresh #(
		.REFRESH_INTERVAL(REFRESH_INTERVAL)
	) sdram_refresh_i (
		.clk_n(clk_n),
		.rst(rst),
		.init_done(init_done),
		.ref_ack(ref_ack),
		.ref_req(ref_req)
	);

	sdram_access #(
		.T_RCD(T_RCD),
		.T_RECOVERY(T_RECOVERY)
	) sdram_access_i (
		.clk_n(clk_n),
		.rst(rst),
		.init_done(init_done),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.acc_req(acc_req),
		.acc_grant(acc_grant),
		.acc_pins(acc_pins),
		.acc_done(acc_done),
		.dq_out(dq_out),
		.dq_oe(dq_oe),
		.dq_in(dq_in)
	);

	sdram_cmd_arbiter #(
		.T_RFC(T_RFC)
	) sdram_cmd_arbiter_i (
		.clk_n(clk_n),
		.rst(rst),
		.init_done(init_done),
		.init_pins(init_pins),
		.ref_req(ref_req),
		.acc_req(acc_req),
		.acc_pins(acc_pins),
		.acc_done(acc_done),
		.ref_ack(ref_ack),
		.acc_grant(acc_grant),
		.pins(pins)
	);

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ns
module tb_clock #(
	parameter int PERIOD = 100
) (
	output logic clk_n
);
	initial
	begin
		clk_n = 1'b0;
		forever
			#(PERIOD / 2) clk_n = ~clk_n;
	end

endmodule

// File: verif/sdram_model.sv
`timescale 1ns/1ns
module sdram_model #(
	parameter int T_RCD = 2,
	parameter int T_RFC = 6,
	parameter int REF_LIMIT = 320
) (
	input logic clk_n,
	input logic cke,
	input sdram_pkg::sdram_cmd_e cmd,
	input logic [12:0] addr,
	input logic [1:0] bank,
	input logic [15:0] dq_out,
	input logic dq_oe,
	output logic [15:0] dq_in,
	output int err_cnt,
	output int ref_cnt
);
	logic [15:0] mem [logic [23:0]]; // {bank, row, column}
	sdram_pkg::sdram_pins_t init_seq[$];
	int init_cyc[$];
	int cycle;
	int act_cyc[4];
	logic [12:0] act_row[4];
	logic [3:0] open_bank;
	int rfc_left;
	int last_ref;
	logic wr_next;
	logic [23:0] wr_key;
	int rd_stage;
	logic [23:0] rd_key;
	logic [23:0] key;

	function automatic logic [15:0] peek(input logic [23:0] k);
		return mem.exists(k) ? mem[k] : 16'h0000;
	endfunction

	task automatic flag(input string what);
		$display("model error at %0t: %s", $time, what);
		err_cnt++;
	endtask

	initial
	begin
		dq_in = '0;
		err_cnt = 0;
		ref_cnt = 0;
		cycle = 0;
		open_bank = '0;
		rfc_left = 0;
		last_ref = 0;
		wr_next = 1'b0;
		rd_stage = 0;
	end

	always @(posedge clk_n)
	begin
		cycle++;
		if (wr_next)
		begin
			assert (dq_oe) else flag("dq_oe low on second write beat");
			mem[wr_key] = dq_out;
			wr_next = 1'b0;
		end
		if (rd_stage == 1) // cas latency 2, low beat first
		begin
			dq_in <= peek(rd_key);
			rd_stage = 2;
		end
		else if (rd_stage == 2)
		begin
			dq_in <= peek(rd_key + 1'b1);
			rd_stage = 0;
		end
		if (rfc_left > 0)
		begin
			assert (cmd == sdram_pkg::CMD_NOP) else flag("command inside refresh cycle time");
			rfc_left--;
		end
		key = {bank, act_row[bank], addr[8:0]};
		if (cke && cmd != sdram_pkg::CMD_NOP && init_seq.size() < 7)
		begin
			init_seq.push_back('{cmd: cmd, addr: addr, bank: bank});
			init_cyc.push_back(cycle);
		end
		else
		begin
			case (cmd)
				sdram_pkg::CMD_ACTIVE:
				begin
					assert (!open_bank[bank]) else flag("ACTIVE on a bank already open");
					open_bank[bank] = 1'b1;
					act_row[bank] = addr;
					act_cyc[bank] = cycle;
				end
				sdram_pkg::CMD_WRITE, sdram_pkg::CMD_READ:
				begin
					assert (open_bank[bank] && cycle - act_cyc[bank] >= T_RCD + 1)
					else flag("READ or WRITE without a timely ACTIVE");
					assert (addr[10]) else flag("auto-precharge bit missing");
					open_bank[bank] = 1'b0;
					if (cmd == sdram_pkg::CMD_WRITE)
					begin
						assert (dq_oe) else flag("dq_oe low on first write beat");
						mem[key] = dq_out;
						wr_key = key + 1'b1;
						wr_next = 1'b1;
					end
					else
					begin
						rd_key = key;
						rd_stage = 1;
					end
				end
				sdram_pkg::CMD_PRECHARGE:
					if (addr[10])
						open_bank = '0;
					else
						open_bank[bank] = 1'b0;
				sdram_pkg::CMD_REFRESH:
				begin
					assert (open_bank == '0) else flag("REFRESH while a bank is open");
					if (last_ref != 0)
						assert (cycle - last_ref <= REF_LIMIT) else flag("refresh came too late");
					last_ref = cycle;
					ref_cnt++;
					rfc_left = T_RFC;
				end
				default:
					;
			endcase
		end
	end

endmodule

// File: verif/sdram_ctrl_tb.sv
`timescale 1ns/1ns
module sdram_ctrl_tb;
	localparam int POWERUP_CYCLES = 200;
	localparam int CMD_GAP = 4;
	localparam int SETTLE_CYCLES = 16;
	localparam int REFRESH_INTERVAL = 300;
	localparam int T_RCD = 2;
	localparam int T_RFC = 6;
	localparam int T_RECOVERY = 3;
	localparam int MAX_ACCESS = 20; // grant wait plus one full read
	localparam int LIMIT = 2000;

	logic clk_n, rst, cke, dq_oe;
	logic [31:0] awaddr, wdata, araddr, rdata;
	logic [3:0] wstrb;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [1:0] bresp, rresp, bank;
	sdram_pkg::sdram_cmd_e cmd;
	logic [12:0] addr;
	logic [15:0] dq_out, dq_in;
	int tb_err, model_err, ref_cnt, fails, base, lo, idx, last, n, c;
	logic [31:0] sb [logic [29:0]]; // keyed by word address
	logic [31:0] pool [8];
	sdram_pkg::sdram_pins_t exp_seq [7];

	tb_clock #(.PERIOD(100)) tb_clock_i (.clk_n(clk_n));

	sdram_ctrl_top #(
		.POWERUP_CYCLES(POWERUP_CYCLES), .CMD_GAP(CMD_GAP), .SETTLE_CYCLES(SETTLE_CYCLES),
		.REFRESH_INTERVAL(REFRESH_INTERVAL), .T_RCD(T_RCD), .T_RFC(T_RFC),
		.T_RECOVERY(T_RECOVERY)
	) sdram_ctrl_top_i (.*);

	sdram_model #(
		.T_RCD(T_RCD), .T_RFC(T_RFC), .REF_LIMIT(REFRESH_INTERVAL + MAX_ACCESS)
	) sdram_model_i (.clk_n(clk_n), .cke(cke), .cmd(cmd), .addr(addr), .bank(bank),
		.dq_out(dq_out), .dq_oe(dq_oe), .dq_in(dq_in),
		.err_cnt(model_err), .ref_cnt(ref_cnt));

	no_cmd_before_cke: assert property (@(posedge clk_n) disable iff (!rst)
		!cke |-> cmd == sdram_pkg::CMD_NOP)
	else
	begin
		$display("error at %0t: command issued while cke low", $time);
		tb_err++;
	end
	no_ready_before_init: assert property (@(posedge clk_n) disable iff (!rst)
		!sdram_ctrl_top_i.init_done |-> !awready && !wready && !arready)
	else
	begin
		$display("error at %0t: ready raised before init", $time);
		tb_err++;
	end
	bvalid_holds: assert property (@(posedge clk_n) disable iff (!rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
	else
	begin
		$display("error at %0t: write response dropped or changed", $time);
		tb_err++;
	end
	rvalid_holds: assert property (@(posedge clk_n) disable iff (!rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
	else
	begin
		$display("error at %0t: read response dropped or changed", $time);
		tb_err++;
	end
	busy_no_ready: assert property (@(posedge clk_n) disable iff (!rst)
		bvalid || rvalid |-> !awready && !arready)
	else
	begin
		$display("error at %0t: new request taken during response", $time);
		tb_err++;
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
			tb_err++;
		end
	endtask

	task automatic give_up(input string what);
		$display("timeout at %0t while waiting for %s", $time, what);
		$display("Test FAILED");
		$finish;
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = tb_err + model_err - base;
		$display("%s: %s, %0d errors", name, errs == 0 ? "passed" : "failed", errs);
		if (errs != 0)
			fails++;
		base = tb_err + model_err;
	endtask

	// a second write stays pending while the response is held back
	task automatic stall_response(input int hold);
		if (hold > 0)
		begin
			@(posedge clk_n);
			awvalid <= 1'b1;
			wvalid <= 1'b1;
			repeat (hold) @(negedge clk_n);
		end
	endtask

	task automatic axi_write(input logic [31:0] a, input logic [31:0] d, input int hold);
		int k;
		@(posedge clk_n);
		awaddr <= a;
		wdata <= d;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		k = 0;
		do
		begin
			@(negedge clk_n);
			k++;
		end while (!(awready && wready) && k < LIMIT);
		if (!(awready && wready))
			give_up("AWREADY");
		@(posedge clk_n);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		sb[a[31:2]] = d;
		k = 0;
		do
		begin
			@(negedge clk_n);
			k++;
		end while (!bvalid && k < LIMIT);
		if (!bvalid)
			give_up("BVALID");
		stall_response(hold); // bready held low
		check_val("bresp", bresp, 2'b00);
		@(posedge clk_n);
		bready <= 1'b1;
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		@(posedge clk_n);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [31:0] a, input int hold);
		int k;
		@(posedge clk_n);
		araddr <= a;
		arvalid <= 1'b1;
		k = 0;
		do
		begin
			@(negedge clk_n);
			k++;
		end while (!arready && k < LIMIT);
		if (!arready)
			give_up("ARREADY");
		@(posedge clk_n);
		arvalid <= 1'b0;
		k = 0;
		do
		begin
			@(negedge clk_n);
			k++;
		end while (!rvalid && k < LIMIT);
		if (!rvalid)
			give_up("RVALID");
		stall_response(hold);
		check_val("rdata", rdata, sb.exists(a[31:2]) ? sb[a[31:2]] : 32'h0);
		check_val("rresp", rresp, 2'b00);
		@(posedge clk_n);
		rready <= 1'b1;
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		@(posedge clk_n);
		rready <= 1'b0;
	endtask

	initial
	begin
		rst = 1'b0;
		{awaddr, wdata, araddr} = '0;
		wstrb = 4'hf;
		{awvalid, wvalid, bready, arvalid, rready} = '0;
		{tb_err, fails, base} = '0;
		void'($urandom(32'h306caa98));
		exp_seq[0] = '{sdram_pkg::CMD_PRECHARGE, 13'h400, 2'd0};
		exp_seq[1] = '{sdram_pkg::CMD_MRS, 13'h000, 2'd1};
		exp_seq[2] = '{sdram_pkg::CMD_MRS, 13'h021, 2'd0};
		exp_seq[3] = '{sdram_pkg::CMD_PRECHARGE, 13'h400, 2'd0};
		exp_seq[4] = '{sdram_pkg::CMD_REFRESH, 13'h000, 2'd0};
		exp_seq[5] = '{sdram_pkg::CMD_REFRESH, 13'h000, 2'd0};
		exp_seq[6] = '{sdram_pkg::CMD_MRS, 13'h021, 2'd0};
		for (int i = 0; i < 8; i++)
			pool[i] = {7'd0, 2'(i % 4), 13'($urandom), 8'($urandom), 2'b00};
		repeat (8) @(posedge clk_n);
		rst <= 1'b1;
		fork
			begin // power-up and init monitor
				lo = 0;
				do
				begin
					@(negedge clk_n);
					if (!cke)
						lo++;
				end while (!cke && lo <= LIMIT);
				check_val("cke low cycles", lo, POWERUP_CYCLES);
				idx = 0;
				last = 0;
				do
				begin
					@(negedge clk_n);
					idx++;
					if (cmd != sdram_pkg::CMD_NOP)
						last = idx;
				end while (!sdram_ctrl_top_i.init_done && idx < LIMIT);
				if (!sdram_ctrl_top_i.init_done)
					give_up("init_done");
				check_val("settle cycles", idx - last, SETTLE_CYCLES);
				check_val("init command count", sdram_model_i.init_seq.size(), 7);
				for (int i = 0; i < 7 && i < sdram_model_i.init_seq.size(); i++)
				begin
					check_val("init command", sdram_model_i.init_seq[i], exp_seq[i]);
					if (i > 0)
						check_val("init gap",
							sdram_model_i.init_cyc[i] - sdram_model_i.init_cyc[i-1],
							CMD_GAP + 1);
				end
				end_test("power-up and init");
			end
			axi_write(pool[0], 32'hcafe_0001, 0); // presented long before init_done
		join
		end_test("early request stall");
		axi_write(pool[5], 32'h1234_5678, 0);
		axi_read(pool[5], 0);
		end_test("write then read");
		for (int i = 0; i < 40; i++)
		begin
			if ($urandom_range(1))
				axi_write(pool[$urandom_range(7)], $urandom, 0);
			else
				axi_read(pool[$urandom_range(7)], 0);
		end
		end_test("random traffic");
		for (int r = 0; r < 3; r++)
		begin
			c = ref_cnt;
			n = 0;
			do
			begin
				@(negedge clk_n);
				n++;
			end while (ref_cnt == c && n <= REFRESH_INTERVAL + MAX_ACCESS);
			if (ref_cnt == c)
				give_up("periodic REFRESH");
		end
		end_test("refresh");
		for (int i = 0; i < 6; i++)
		begin
			axi_write(pool[i], $urandom, $urandom_range(1, 8));
			axi_read(pool[i], $urandom_range(1, 8));
		end
		end_test("back-pressure");
		$display("tests 6, failed %0d, errors %0d", fails, tb_err + model_err);
		if (fails == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: flist.f
design/sdram_pkg.sv
design/sdram_init.sv
design/sdram_refresh.sv
design/sdram_access.sv
design/sdram_cmd_arbiter.sv
design/sdram_ctrl_top.sv
verif/tb_clock.sv
verif/sdram_model.sv
verif/sdram_ctrl_tb.sv
